// ==== filelist.f ====
source/mipsPkg.sv
source/controlIf.sv
source/ifetch.sv
source/control.sv
source/idecode.sv
source/alu.sv
source/dmemory.sv
source/mipsCore.sv
bench/mipsRefPkg.sv
bench/mipsCoreTb.sv

// ==== Bender.yml ====
package:
  name: mips_core

sources:
  - source/mipsPkg.sv
  - source/controlIf.sv
  - source/ifetch.sv
  - source/control.sv
  - source/idecode.sv
  - source/alu.sv
  - source/dmemory.sv
  - source/mipsCore.sv
  - target: test
    files:
      - bench/mipsRefPkg.sv
      - bench/mipsCoreTb.sv

// ==== bench/mipsCoreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mipsCoreTb
    import mipsPkg::*, mipsRefPkg::*;
();
    localparam int numTests   = 5;
    localparam int progLen    = progWords - 1;
    localparam int cycleLimit = numTests * (progLen + progWords + 20);

    logic                 clock;
    logic                 arstN;
    logic                 run;
    logic                 imemWe;
    logic [wordWidth-1:0] imemAddr;
    logic [wordWidth-1:0] imemData;
    logic [wordWidth-1:0] pc;
    logic                 wbEn;
    regAddrT              wbAddr;
    logic [wordWidth-1:0] wbData;
    logic                 stEn;
    logic [wordWidth-1:0] stAddr;
    logic [wordWidth-1:0] stData;

    progT        prog;
    logic [31:0] refRegs [32];
    logic [31:0] refMem [memWords];  // kept across tests like the data memory
    logic [31:0] refPc;
    traceT       expected;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    int          testErrors;
    int          executed;

    mipsCore #(.imemDepth(256), .dmemDepth(memWords)) mipsCore_i (
        .clock(clock), .arstN(arstN), .run(run),
        .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
        .pc(pc), .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData),
        .stEn(stEn), .stAddr(stAddr), .stData(stData)
    );

    always #10 clock = ~clock;  // 20 ns period

    always @(posedge clock) begin
        cycles++;
        if (cycles >= cycleLimit) begin
            $display("Timeout: the core did not reach the self-loop within %0d cycles", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic compareValue(input string what, input logic [31:0] got,
                                input logic [31:0] want);
        checks++;
        assert (got === want)
        else begin
            $display("Fail at time %0t: %s is %h, model expects %h", $time, what, got, want);
            errors++;
            testErrors++;
        end
    endtask

    task automatic resetCore();
        arstN = 1'b0;
        run   = 1'b0;
        repeat (8) @(posedge clock);
        #2;
        arstN = 1'b1;
    endtask

    // core idle, so no trace may fire
    task automatic loadProgram();
        for (int w = 0; w < progWords; w++) begin
            @(posedge clock);
            #2;
            imemWe   = 1'b1;
            imemAddr = 32'(w * 4);
            imemData = prog[w];
            @(negedge clock);
            compareValue("pc while idle", pc, 32'h0);
            compareValue("wbEn while idle", 32'(wbEn), 32'h0);
            compareValue("stEn while idle", 32'(stEn), 32'h0);
        end
        @(posedge clock);
        #2;
        imemWe = 1'b0;
    endtask

    task automatic runProgram();
        bit atLoop;
        for (int r = 0; r < 32; r++) begin
            refRegs[r] = '0;
        end
        refPc    = '0;
        executed = 0;
        atLoop   = 1'b0;
        run      = 1'b1;
        while (!atLoop) begin
            @(negedge clock);  // trace settled, next edge commits it
            atLoop = (refPc == 32'(progLen * 4));
            execute(prog[int'(refPc >> 2) % progWords], refRegs, refMem, refPc, expected);
            compareValue("pc", pc, expected.pc);
            compareValue("wbEn", 32'(wbEn), 32'(expected.wbEn));
            if (expected.wbEn) begin
                compareValue("wbAddr", 32'(wbAddr), 32'(expected.wbAddr));
                compareValue("wbData", wbData, expected.wbData);
            end
            compareValue("stEn", 32'(stEn), 32'(expected.stEn));
            if (expected.stEn) begin
                compareValue("stAddr", stAddr, expected.stAddr);
                compareValue("stData", stData, expected.stData);
            end
            if (!atLoop) begin
                executed++;
            end
            @(posedge clock);
            #2;
        end
        run = 1'b0;
    endtask

    initial begin
        clock    = 1'b0;
        arstN    = 1'b0;
        run      = 1'b0;
        imemWe   = 1'b0;
        imemAddr = '0;
        imemData = '0;
        void'($urandom(32'hd4768134));
        for (int t = 0; t < numTests; t++) begin
            testErrors = 0;
            makeProgram(t % 2 == 1, prog);  // word 0 alternates between a store and a lui
            @(posedge clock);
            #2;
            resetCore();  // pc back to 0 for the new program
            loadProgram();
            runProgram();
            $display("test %0d: %0d instructions executed, %0d mismatches",
                     t + 1, executed, testErrors);
        end
        $display("tests %0d, checks %0d, errors %0d", numTests, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/mipsRefPkg.sv ====
`default_nettype none

package mipsRefPkg;
    import mipsPkg::*;

    localparam int progWords = 49;   // 48 random words and the self-loop
    localparam int memWords  = 256;

    typedef logic [31:0] progT [progWords];

    typedef struct packed {
        logic        wbEn;
        logic [4:0]  wbAddr;
        logic [31:0] wbData;
        logic        stEn;
        logic [31:0] stAddr;
        logic [31:0] stData;
        logic [31:0] pc;
    } traceT;

    function automatic logic [31:0] rWord(input logic [5:0] fn, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [4:0] sh);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] iWord(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jWord(input logic [5:0] op, input int target);
        return {op, 26'(target)};  // word index of the target
    endfunction

    // one instruction without control flow, never writes $31
    function automatic logic [31:0] randomOp(input logic [15:0] slots [4]);
        logic [5:0]  fns [16];
        logic [5:0]  ops [8];
        logic [4:0]  dst;
        logic [4:0]  src1;
        logic [4:0]  src2;
        logic [15:0] slot;
        fns  = '{fnSll, fnSrl, fnSra, fnSllv, fnSrlv, fnSrav, fnAdd, fnAddu,
                 fnSub, fnSubu, fnAnd, fnOr, fnXor, fnNor, fnSlt, fnSltu};
        ops  = '{opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui};
        dst  = 5'($urandom % 31);  // $0 included on purpose
        src1 = 5'($urandom % 32);
        src2 = 5'($urandom % 32);
        slot = slots[$urandom % 4];
        case ($urandom % 8)
            0, 1, 2: return rWord(fns[$urandom % 16], src1, src2, dst, 5'($urandom));
            3, 4, 5: return iWord(ops[$urandom % 8], src1, dst, 16'($urandom));
            6:       return iWord(opLw, 5'd0, dst, slot);
            default: return iWord(opSw, 5'd0, src2, slot);
        endcase
    endfunction

    // stores first so every load slot holds data, then forward-only control flow
    task automatic makeProgram(input bit leadLui, output progT prog);
        logic [15:0] slots [4];
        int          blockEnd [progWords];  // jr that closes a call block
        bit          covered [progWords];   // no branch may land here
        int          first;
        int          i;
        int          t;
        int          len;
        logic [4:0]  a;
        logic [4:0]  b;
        for (i = 0; i < progWords; i++) begin
            blockEnd[i] = 0;
            covered[i]  = 1'b0;
        end
        first = leadLui ? 1 : 0;
        if (leadLui) begin
            prog[0] = iWord(opLui, 5'd0, 5'(1 + $urandom % 30), 16'($urandom));  // word 0 writes a register
        end
        for (i = 0; i < 4; i++) begin
            slots[i]        = 16'(($urandom % 256) * 4);  // aligned, below 1 KB
            prog[first + i] = iWord(opSw, 5'd0, 5'($urandom % 32), slots[i]);
        end
        i = first + 4;
        while (i < progWords - 1) begin
            len = 1 + $urandom % 4;
            if ($urandom % 6 == 0 && i + len + 2 < progWords - 1) begin
                blockEnd[i] = i + len + 2;
                for (t = i + 1; t <= blockEnd[i]; t++) begin
                    covered[t] = 1'b1;
                end
                i = blockEnd[i] + 1;
            end else begin
                i++;
            end
        end
        i = first + 4;
        while (i < progWords - 1) begin
            if (blockEnd[i] != 0) begin
                prog[i]     = jWord(opJal, i + 2);
                prog[i + 1] = jWord(opJ, blockEnd[i] + 1);  // return lands here
                for (t = i + 2; t < blockEnd[i]; t++) begin
                    prog[t] = randomOp(slots);
                end
                prog[blockEnd[i]] = rWord(fnJr, 5'd31, 5'd0, 5'd0, 5'd0);
                i = blockEnd[i] + 1;
            end else begin
                if ($urandom % 5 == 0) begin
                    t = i + 1 + $urandom % 4;
                    while (t < progWords - 1 && covered[t]) begin
                        t++;
                    end
                    if (t > progWords - 1) begin
                        t = progWords - 1;
                    end
                    a = 5'($urandom % 32);
                    b = ($urandom % 3 == 0) ? a : 5'($urandom % 32);  // equal regs give taken beq
                    case ($urandom % 3)
                        0:       prog[i] = iWord(opBeq, a, b, 16'(t - i - 1));
                        1:       prog[i] = iWord(opBne, a, b, 16'(t - i - 1));
                        default: prog[i] = jWord(opJ, t);
                    endcase
                end else begin
                    prog[i] = randomOp(slots);
                end
                i++;
            end
        end
        prog[progWords - 1] = jWord(opJ, progWords - 1);  // self-loop
    endtask

    function automatic logic [31:0] rTypeResult(input logic [5:0] fn, input logic [31:0] a,
                                                input logic [31:0] b, input logic [4:0] sh);
        case (fn)
            fnSll:         return b << sh;
            fnSrl:         return b >> sh;
            fnSra:         return $signed(b) >>> sh;
            fnSllv:        return b << a[4:0];
            fnSrlv:        return b >> a[4:0];
            fnSrav:        return $signed(b) >>> a[4:0];
            fnAdd, fnAddu: return a + b;
            fnSub, fnSubu: return a - b;
            fnAnd:         return a & b;
            fnOr:          return a | b;
            fnXor:         return a ^ b;
            fnNor:         return ~(a | b);
            fnSlt:         return {31'b0, $signed(a) < $signed(b)};
            fnSltu:        return {31'b0, a < b};
            default:       return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] iTypeResult(input logic [5:0] op, input logic [31:0] a,
                                                input logic [31:0] simm, input logic [31:0] zimm);
        case (op)
            opAddi, opAddiu: return a + simm;
            opSlti:          return {31'b0, $signed(a) < $signed(simm)};
            opSltiu:         return {31'b0, a < simm};
            opAndi:          return a & zimm;
            opOri:           return a | zimm;
            opXori:          return a ^ zimm;
            opLui:           return {zimm[15:0], 16'h0000};
            default:         return 32'h0;
        endcase
    endfunction

    // architectural effect of one instruction, plus the trace it should show
    task automatic execute(input logic [31:0] instr, inout logic [31:0] regs [32],
                           inout logic [31:0] mem [memWords], inout logic [31:0] pc,
                           output traceT tr);
        logic [5:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] pc4;
        logic [31:0] nextPc;
        logic [31:0] addr;
        op     = instr[31:26];
        a      = (instr[25:21] == 5'd0) ? 32'h0 : regs[instr[25:21]];
        b      = (instr[20:16] == 5'd0) ? 32'h0 : regs[instr[20:16]];
        simm   = {{16{instr[15]}}, instr[15:0]};
        pc4    = pc + 32'd4;
        nextPc = pc4;
        addr   = a + simm;
        tr     = '0;
        tr.pc  = pc;
        case (op)
            opRType: begin
                if (instr[5:0] == fnJr) begin
                    nextPc = a;
                end else begin
                    tr.wbEn   = 1'b1;
                    tr.wbAddr = instr[15:11];
                    tr.wbData = rTypeResult(instr[5:0], a, b, instr[10:6]);
                end
            end
            opJ: nextPc = {pc[31:28], instr[25:0], 2'b00};
            opJal: begin
                nextPc    = {pc[31:28], instr[25:0], 2'b00};
                tr.wbEn   = 1'b1;
                tr.wbAddr = 5'd31;
                tr.wbData = pc4;
            end
            opBeq: begin
                if (a == b) begin
                    nextPc = pc4 + (simm << 2);
                end
            end
            opBne: begin
                if (a != b) begin
                    nextPc = pc4 + (simm << 2);
                end
            end
            opLw: begin
                tr.wbEn   = 1'b1;
                tr.wbAddr = instr[20:16];
                tr.wbData = mem[(addr >> 2) % memWords];
            end
            opSw: begin
                tr.stEn   = 1'b1;
                tr.stAddr = addr;
                tr.stData = b;
                mem[(addr >> 2) % memWords] = b;
            end
            default: begin
                tr.wbEn   = 1'b1;
                tr.wbAddr = instr[20:16];
                tr.wbData = iTypeResult(op, a, simm, {16'h0000, instr[15:0]});
            end
        endcase
        if (tr.wbEn && tr.wbAddr != 5'd0) begin
            regs[tr.wbAddr] = tr.wbData;
        end
        pc = nextPc;
    endtask

endpackage

`default_nettype wire

// ==== source/mipsCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module mipsCore
    import mipsPkg::*;
#(
    parameter int imemDepth = 256,
    parameter int dmemDepth = 256
) (
    input  logic                 clock,
    input  logic                 arstN,
    input  logic                 run,
    input  logic                 imemWe,    // instruction load port
    input  logic [wordWidth-1:0] imemAddr,
    input  logic [wordWidth-1:0] imemData,
    output logic [wordWidth-1:0] pc,
    output logic                 wbEn,      // register write trace
    output regAddrT              wbAddr,
    output logic [wordWidth-1:0] wbData,
    output logic                 stEn,      // store trace
    output logic [wordWidth-1:0] stAddr,
    output logic [wordWidth-1:0] stData
);
    logic [wordWidth-1:0] instruction;
    logic [wordWidth-1:0] pcPlus4;
    logic [wordWidth-1:0] readData1;
    logic [wordWidth-1:0] readData2;
    logic [wordWidth-1:0] signExtend;
    logic [wordWidth-1:0] aluResult;
    logic                 zero;
    logic [wordWidth-1:0] addrResult;
    logic [wordWidth-1:0] memData;
    logic                 regWriteDec;

    controlIf ctlBus ();

    ifetch #(.imemDepth(imemDepth)) ifetch_i (
        .clock(clock), .arstN(arstN), .run(run),
        .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
        .addrResult(addrResult), .zero(zero), .readData1(readData1),
        .ctl(ctlBus.fetch),
        .instruction(instruction), .pcPlus4(pcPlus4), .pc(pc)
    );

    control control_i (
        .opcode(instruction[31:26]), .funct(instruction[5:0]), .ctl(ctlBus.ctrl)
    );

    idecode idecode_i (
        .clock(clock), .arstN(arstN), .run(run),
        .instruction(instruction), .aluResult(aluResult), .memData(memData),
        .pcPlus4(pcPlus4), .ctl(ctlBus.decode),
        .readData1(readData1), .readData2(readData2), .signExtend(signExtend),
        .wbEn(regWriteDec), .wbAddr(wbAddr), .wbData(wbData)
    );

    alu alu_i (
        .readData1(readData1), .readData2(readData2), .signExtend(signExtend),
        .functionOpcode(instruction[5:0]), .exeOpcode(instruction[31:26]),
        .shamt(instruction[10:6]), .pcPlus4(pcPlus4), .ctl(ctlBus.exec),
        .aluResult(aluResult), .zero(zero), .addrResult(addrResult)
    );

    dmemory #(.dmemDepth(dmemDepth)) dmemory_i (
        .clock(clock), .arstN(arstN), .run(run),
        .address(aluResult), .writeData(readData2), .ctl(ctlBus.mem),
        .readData(memData)
    );

    // trace shows what the next edge commits
    assign wbEn   = regWriteDec & run;
    assign stEn   = ctlBus.memWrite & run;
    assign stAddr = aluResult;
    assign stData = readData2;

endmodule

`default_nettype wire

// ==== source/dmemory.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmemory
    import mipsPkg::*;
#(
    parameter int dmemDepth = 256
) (
    input  logic                 clock,
    input  logic                 arstN,
    input  logic                 run,
    input  logic [wordWidth-1:0] address,    // byte address from alu
    input  logic [wordWidth-1:0] writeData,
    controlIf.mem                ctl,
    output logic [wordWidth-1:0] readData
);
    localparam int idxWidth = $clog2(dmemDepth);

    logic [wordWidth-1:0] mem [dmemDepth];
    logic [idxWidth-1:0]  wordIdx;

    assign wordIdx  = idxWidth'((address >> 2) % dmemDepth);  // wraps at depth
    assign readData = mem[wordIdx];

    always_ff @(posedge clock) begin
        if (run && ctl.memWrite) begin
            mem[wordIdx] <= writeData;
        end
    end

    storeAligned: assert property (@(posedge clock) disable iff (!arstN)
        (run && ctl.memWrite) |-> (address[1:0] == 2'b00))
        else $error("unaligned store to %h", address);

endmodule

`default_nettype wire

// ==== source/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu
    import mipsPkg::*;
(
    input  logic [wordWidth-1:0] readData1,
    input  logic [wordWidth-1:0] readData2,
    input  logic [wordWidth-1:0] signExtend,      // extended immediate
    input  logic [5:0]           functionOpcode,  // instruction[5:0]
    input  logic [5:0]           exeOpcode,       // instruction[31:26]
    input  logic [4:0]           shamt,           // instruction[10:6]
    input  logic [wordWidth-1:0] pcPlus4,
    controlIf.exec               ctl,
    output logic [wordWidth-1:0] aluResult,
    output logic                 zero,
    output logic [wordWidth-1:0] addrResult
);
    logic [wordWidth-1:0] aInput;
    logic [wordWidth-1:0] bInput;
    logic [5:0]           exeCode;
    logic [2:0]           aluCtl;
    logic                 isArith;
    logic                 isBranch;
    logic [2:0]           sftm;
    logic [wordWidth-1:0] shiftResult;
    logic [wordWidth-1:0] aluMux;
    logic                 isSlt;
    logic                 isSltu;

    assign aInput = readData1;
    assign bInput = ctl.aluSrc ? signExtend : readData2;

    assign isArith  = ctl.aluOp[1];  // R-type or I-type arithmetic
    assign isBranch = (ctl.aluOp == aluBranch);

    // I-type ops reuse the low opcode bits as a pseudo function code
    assign exeCode   = ctl.iFormat ? {3'b000, exeOpcode[2:0]} : functionOpcode;
    assign aluCtl[0] = (exeCode[0] | exeCode[3]) & isArith;
    assign aluCtl[1] = ~exeCode[2] | ~isArith;
    assign aluCtl[2] = (exeCode[1] & isArith) | isBranch;

    always_comb begin
        case (aluCtl)
            3'b000:         aluMux = aInput & bInput;
            3'b001:         aluMux = aInput | bInput;
            3'b010, 3'b011: aluMux = aInput + bInput;  // no overflow trap
            3'b100:         aluMux = aInput ^ bInput;
            3'b101:         aluMux = ~(aInput | bInput);
            default:        aluMux = aInput - bInput;  // sub, compare
        endcase
    end

    assign sftm = functionOpcode[2:0];

    always_comb begin
        case (sftm)
            3'b000:  shiftResult = bInput << shamt;
            3'b010:  shiftResult = bInput >> shamt;
            3'b011:  shiftResult = $signed(bInput) >>> shamt;
            3'b100:  shiftResult = bInput << aInput[4:0];  // variable, low 5 bits
            3'b110:  shiftResult = bInput >> aInput[4:0];
            3'b111:  shiftResult = $signed(bInput) >>> aInput[4:0];
            default: shiftResult = bInput;
        endcase
    end

    assign isSlt  = (ctl.iFormat && exeOpcode == opSlti) ||
                    (ctl.aluOp == aluRType && functionOpcode == fnSlt);
    assign isSltu = (ctl.iFormat && exeOpcode == opSltiu) ||
                    (ctl.aluOp == aluRType && functionOpcode == fnSltu);

    always_comb begin
        if (ctl.jr) begin
            aluResult = aInput;  // jump target passes through
        end else if (isSlt) begin
            aluResult = {31'b0, $signed(aInput) < $signed(bInput)};
        end else if (isSltu) begin
            aluResult = {31'b0, aInput < bInput};
        end else if (aluCtl == 3'b101 && ctl.iFormat) begin
            aluResult = bInput << 16;  // lui
        end else if (ctl.sftmd) begin
            aluResult = shiftResult;
        end else begin
            aluResult = aluMux;
        end
    end

    assign zero = (aluResult == '0);  // rs - rt for beq, bne

    assign addrResult = pcPlus4 + (signExtend << 2);

endmodule

`default_nettype wire

// ==== source/idecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module idecode
    import mipsPkg::*;
(
    input  logic                 clock,
    input  logic                 arstN,
    input  logic                 run,
    input  logic [wordWidth-1:0] instruction,
    input  logic [wordWidth-1:0] aluResult,
    input  logic [wordWidth-1:0] memData,    // load data from dmemory
    input  logic [wordWidth-1:0] pcPlus4,    // link value for jal
    controlIf.decode             ctl,
    output logic [wordWidth-1:0] readData1,
    output logic [wordWidth-1:0] readData2,
    output logic [wordWidth-1:0] signExtend,
    output logic                 wbEn,
    output regAddrT              wbAddr,
    output logic [wordWidth-1:0] wbData
);
    logic [wordWidth-1:0] regFile [32];
    regAddrT              rs;
    regAddrT              rt;
    regAddrT              rd;
    logic [15:0]          imm;

    assign rs  = instruction[25:21];
    assign rt  = instruction[20:16];
    assign rd  = instruction[15:11];
    assign imm = instruction[15:0];

    // $0 is cleared by reset and never written
    assign readData1 = regFile[rs];
    assign readData2 = regFile[rt];

    assign signExtend = ctl.zeroExt ? {16'h0000, imm} : {{16{imm[15]}}, imm};

    always_comb begin
        if (ctl.jal) begin
            wbAddr = 5'd31;
        end else if (ctl.regDst) begin
            wbAddr = rd;
        end else begin
            wbAddr = rt;
        end
    end

    always_comb begin
        if (ctl.jal) begin
            wbData = pcPlus4;
        end else if (ctl.memToReg) begin
            wbData = memData;
        end else begin
            wbData = aluResult;
        end
    end

    assign wbEn = ctl.regWrite;

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regFile[i] <= '0;
            end
        end else if (run && ctl.regWrite && wbAddr != '0) begin
            regFile[wbAddr] <= wbData;  // $0 is never written
        end
    end

    regZeroKept: assert property (@(posedge clock) disable iff (!arstN)
        (rs != '0 || readData1 == '0) && (rt != '0 || readData2 == '0))
        else $error("$0 read back nonzero");

endmodule

`default_nettype wire

// ==== source/control.sv ====
`timescale 1ns/1ps
`default_nettype none

module control
    import mipsPkg::*;
(
    input  logic [5:0] opcode,  // instruction[31:26]
    input  logic [5:0] funct,   // instruction[5:0]
    controlIf.ctrl     ctl
);
    opcodeT op;
    functT  fn;

    assign op = opcodeT'(opcode);
    assign fn = functT'(funct);

    always_comb begin
        ctl.regDst   = 1'b0;
        ctl.regWrite = 1'b0;
        ctl.memToReg = 1'b0;
        ctl.memWrite = 1'b0;
        ctl.aluSrc   = 1'b0;
        ctl.iFormat  = 1'b0;
        ctl.sftmd    = 1'b0;
        ctl.zeroExt  = 1'b0;
        ctl.branch   = 1'b0;
        ctl.nBranch  = 1'b0;
        ctl.jmp      = 1'b0;
        ctl.jal      = 1'b0;
        ctl.jr       = 1'b0;
        ctl.aluOp    = aluMemAdd;
        case (op)
            opRType: begin
                ctl.regDst = 1'b1;
                ctl.aluOp  = aluRType;
                case (fn)
                    fnSll, fnSrl, fnSra, fnSllv, fnSrlv, fnSrav: begin
                        ctl.sftmd    = 1'b1;
                        ctl.regWrite = 1'b1;
                    end
                    fnJr: ctl.jr = 1'b1;
                    fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr, fnXor, fnNor,
                    fnSlt, fnSltu: ctl.regWrite = 1'b1;
                    default: ;  // unsupported function, no write
                endcase
            end
            opJ: ctl.jmp = 1'b1;
            opJal: begin
                ctl.jal      = 1'b1;
                ctl.regWrite = 1'b1;  // link into $31
            end
            opBeq: begin
                ctl.branch = 1'b1;
                ctl.aluOp  = aluBranch;
            end
            opBne: begin
                ctl.nBranch = 1'b1;
                ctl.aluOp   = aluBranch;
            end
            opAddi, opAddiu, opSlti, opSltiu, opLui, opAndi, opOri, opXori: begin
                ctl.iFormat  = 1'b1;
                ctl.aluSrc   = 1'b1;
                ctl.regWrite = 1'b1;
                ctl.aluOp    = aluIArith;
                ctl.zeroExt  = (op == opAndi) || (op == opOri) || (op == opXori);
            end
            opLw: begin
                ctl.aluSrc   = 1'b1;
                ctl.memToReg = 1'b1;
                ctl.regWrite = 1'b1;
            end
            opSw: begin
                ctl.aluSrc   = 1'b1;
                ctl.memWrite = 1'b1;
            end
            default: ;  // unknown opcode acts as a no-op
        endcase
    end

endmodule

`default_nettype wire

// ==== source/ifetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module ifetch
    import mipsPkg::*;
#(
    parameter int imemDepth = 256
) (
    input  logic                 clock,
    input  logic                 arstN,
    input  logic                 run,
    input  logic                 imemWe,
    input  logic [wordWidth-1:0] imemAddr,
    input  logic [wordWidth-1:0] imemData,
    input  logic [wordWidth-1:0] addrResult,  // branch target from alu
    input  logic                 zero,
    input  logic [wordWidth-1:0] readData1,   // jr target
    controlIf.fetch              ctl,
    output logic [wordWidth-1:0] instruction,
    output logic [wordWidth-1:0] pcPlus4,
    output logic [wordWidth-1:0] pc
);
    localparam int idxWidth = $clog2(imemDepth);

    logic [wordWidth-1:0] imem [imemDepth];
    logic [idxWidth-1:0]  fetchIdx;
    logic [idxWidth-1:0]  loadIdx;
    logic [wordWidth-1:0] nextPc;
    logic                 takeBranch;

    assign fetchIdx    = idxWidth'((pc >> 2) % imemDepth);      // byte address to word slot
    assign loadIdx     = idxWidth'((imemAddr >> 2) % imemDepth);
    assign instruction = imem[fetchIdx];
    assign pcPlus4     = pc + 32'd4;

    assign takeBranch = (ctl.branch & zero) | (ctl.nBranch & ~zero);

    always_comb begin
        if (ctl.jr) begin
            nextPc = readData1;
        end else if (ctl.jmp || ctl.jal) begin
            nextPc = {pc[31:28], instruction[25:0], 2'b00};     // pseudo-direct target
        end else if (takeBranch) begin
            nextPc = addrResult;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (run) begin
            pc <= nextPc;
        end
    end

    always_ff @(posedge clock) begin
        if (imemWe) begin
            imem[loadIdx] <= imemData;  // load port
        end
    end

    pcAligned: assert property (@(posedge clock) disable iff (!arstN) pc[1:0] == 2'b00)
        else $error("pc left word alignment: %h", pc);

endmodule

`default_nettype wire

// ==== source/controlIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface controlIf
    import mipsPkg::*;
();
    logic  regDst;     // rd instead of rt
    logic  regWrite;
    logic  memToReg;   // write back load data
    logic  memWrite;
    logic  aluSrc;     // second operand is the immediate
    logic  iFormat;    // I-type arithmetic and logic
    logic  sftmd;      // shift instruction
    logic  zeroExt;    // andi, ori, xori
    logic  branch;     // beq
    logic  nBranch;    // bne
    logic  jmp;
    logic  jal;
    logic  jr;
    aluOpT aluOp;

    modport ctrl (
        output regDst, regWrite, memToReg, memWrite, aluSrc, iFormat, sftmd,
        output zeroExt, branch, nBranch, jmp, jal, jr, aluOp
    );
    modport fetch (input branch, nBranch, jmp, jal, jr);
    modport decode (input regDst, regWrite, memToReg, jal, zeroExt);
    modport exec (input aluOp, aluSrc, iFormat, sftmd, jr);
    modport mem (input memWrite);

endinterface

`default_nettype wire

// ==== source/mipsPkg.sv ====
`default_nettype none

package mipsPkg;

    localparam int wordWidth = 32;

    typedef logic [4:0] regAddrT;

    typedef enum logic [5:0] {
        opRType = 6'h00,
        opJ     = 6'h02,
        opJal   = 6'h03,
        opBeq   = 6'h04,
        opBne   = 6'h05,
        opAddi  = 6'h08,
        opAddiu = 6'h09,
        opSlti  = 6'h0a,
        opSltiu = 6'h0b,
        opAndi  = 6'h0c,
        opOri   = 6'h0d,
        opXori  = 6'h0e,
        opLui   = 6'h0f,
        opLw    = 6'h23,
        opSw    = 6'h2b
    } opcodeT;

    typedef enum logic [5:0] {
        fnSll  = 6'h00,
        fnSrl  = 6'h02,
        fnSra  = 6'h03,
        fnSllv = 6'h04,
        fnSrlv = 6'h06,
        fnSrav = 6'h07,
        fnJr   = 6'h08,
        fnAdd  = 6'h20,
        fnAddu = 6'h21,
        fnSub  = 6'h22,
        fnSubu = 6'h23,
        fnAnd  = 6'h24,
        fnOr   = 6'h25,
        fnXor  = 6'h26,
        fnNor  = 6'h27,
        fnSlt  = 6'h2a,
        fnSltu = 6'h2b
    } functT;

    // bit 1 marks the arithmetic classes, bit 0 alone marks a branch
    typedef enum logic [1:0] {
        aluMemAdd = 2'b00,
        aluBranch = 2'b01,
        aluRType  = 2'b10,
        aluIArith = 2'b11
    } aluOpT;

endpackage

`default_nettype wire
